/* source/cache_pkg.sv */
// cache widths, vector typedefs and the refill state encoding
package cache_pkg;

    // ====================
    // address split
    // ====================
    localparam int ADDR_WIDTH   = 16;
    localparam int OFFSET_WIDTH = 4;
    localparam int INDEX_WIDTH  = 5;
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    // data and organisation
    localparam int WORD_WIDTH     = 32;
    localparam int LINE_WIDTH     = 128;
    localparam int WORDS_PER_LINE = LINE_WIDTH / WORD_WIDTH;
    localparam int NUM_WAYS       = 2;

    // ====================
    // vector types
    // ====================
    typedef logic [ADDR_WIDTH-1:0]             addr_t;
    typedef logic [TAG_WIDTH-1:0]              tag_t;
    typedef logic [INDEX_WIDTH-1:0]            index_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;
    typedef logic [WORD_WIDTH-1:0]             word_t;
    typedef logic [LINE_WIDTH-1:0]             line_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]       way_t;

    // miss controller states
    typedef enum logic [2:0] {
        IDLE,
        WRITEBACK,
        FETCH_REQ,
        FETCH_WAIT,
        DONE
    } refill_state_t;

endpackage

/* source/cache_if.sv */
// req_stage_if, set_read_if, line_write_if and refill_if with their modports

// stage one item as seen by stage two, hold goes back upstream
interface req_stage_if;
    import cache_pkg::*;
    logic  valid;
    logic  write;
    addr_t addr;
    word_t wdata;
    logic  hold;
    modport lookup  (output valid, write, addr, wdata, input hold);
    modport resolve (input valid, write, addr, wdata, output hold);
endinterface

// registered contents of one set, both ways
interface set_read_if;
    import cache_pkg::*;
    tag_t                tag [NUM_WAYS];
    logic [NUM_WAYS-1:0] valid;
    logic [NUM_WAYS-1:0] dirty;
    line_t               line [NUM_WAYS];
    way_t                lru;
    modport arrays  (output tag, valid, dirty, line, lru);
    modport resolve (input tag, valid, dirty, line, lru);
endinterface

// single way update plus LRU touch
interface line_write_if;
    import cache_pkg::*;
    logic   we;
    logic   touch;
    way_t   way;
    index_t index;
    tag_t   tag;
    logic   dirty;
    line_t  line;
    modport resolve (output we, touch, way, index, tag, dirty, line);
    modport arrays  (input we, touch, way, index, tag, dirty, line);
endinterface

// miss hand-off between resolve and the refill controller
interface refill_if;
    import cache_pkg::*;
    logic  start;
    logic  victim_dirty;
    addr_t victim_addr;
    line_t victim_line;
    addr_t fill_addr;
    logic  done;
    line_t fill_line;
    modport resolve (output start, victim_dirty, victim_addr, victim_line, fill_addr,
                     input done, fill_line);
    modport refill  (input start, victim_dirty, victim_addr, victim_line, fill_addr,
                     output done, fill_line);
endinterface

/* source/cache_arrays.sv */
// cache_arrays: tag, valid, dirty, line and LRU storage, write-first synchronous read
module cache_arrays (
    input  logic              clk,
    input  logic              rstn,
    input  cache_pkg::index_t rd_index,
    set_read_if.arrays        rd,
    line_write_if.arrays      wr
);
    import cache_pkg::*;

    tag_t  tag_mem  [NUM_WAYS][1 << INDEX_WIDTH];
    line_t line_mem [NUM_WAYS][1 << INDEX_WIDTH];

    logic [NUM_WAYS-1:0][(1 << INDEX_WIDTH)-1:0] valid_mem;
    logic [NUM_WAYS-1:0][(1 << INDEX_WIDTH)-1:0] dirty_mem;
    logic [(1 << INDEX_WIDTH)-1:0]               lru_mem;

    // per way: write lands on the set being read
    logic [NUM_WAYS-1:0] fwd;
    logic                lru_fwd;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            fwd[w] = wr.we && (wr.way == way_t'(w)) && (wr.index == rd_index);
        end
    end

    assign lru_fwd = wr.touch && (wr.index == rd_index);

    // ====================
    // payload storage
    // ====================
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (wr.we && (wr.way == way_t'(w))) begin
                tag_mem[w][wr.index]  <= wr.tag;
                line_mem[w][wr.index] <= wr.line;
            end
            rd.tag[w]  <= fwd[w] ? wr.tag  : tag_mem[w][rd_index];
            rd.line[w] <= fwd[w] ? wr.line : line_mem[w][rd_index];
        end
    end

    // ====================
    // state bits
    // ====================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_mem <= '0;
            dirty_mem <= '0;
            lru_mem   <= '0;
            rd.valid  <= '0;
            rd.dirty  <= '0;
            rd.lru    <= '0;
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (wr.we && (wr.way == way_t'(w))) begin
                    valid_mem[w][wr.index] <= 1'b1;
                    dirty_mem[w][wr.index] <= wr.dirty;
                end
                rd.valid[w] <= fwd[w] ? 1'b1     : valid_mem[w][rd_index];
                rd.dirty[w] <= fwd[w] ? wr.dirty : dirty_mem[w][rd_index];
            end
            // lru bit names the way to evict next
            if (wr.touch) begin
                lru_mem[wr.index] <= ~wr.way;
            end
            rd.lru <= lru_fwd ? ~wr.way : lru_mem[rd_index];
        end
    end

endmodule

/* source/cache_lookup.sv */
// cache_lookup: stage one request register and array read index select
module cache_lookup (
    input  logic              clk,
    input  logic              rstn,
    input  logic              req_valid,
    input  logic              req_write,
    input  cache_pkg::addr_t  req_addr,
    input  cache_pkg::word_t  req_wdata,
    output logic              req_ready,
    output cache_pkg::index_t rd_index,
    req_stage_if.lookup       stage
);
    import cache_pkg::*;

    logic accept;

    // no new work while stage two waits on a miss
    assign req_ready = !stage.hold;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stage.valid <= 1'b0;
        end else if (!stage.hold) begin
            stage.valid <= req_valid;
        end
    end

    // request fields, kept as is during hold
    always_ff @(posedge clk) begin
        if (accept) begin
            stage.write <= req_write;
            stage.addr  <= req_addr;
            stage.wdata <= req_wdata;
        end
    end

    // ====================
    // array read index
    // ====================
    // held index re-read every cycle so an installed line
    // shows up for the waiting item
    always_comb begin
        if (accept) begin
            rd_index = req_addr[OFFSET_WIDTH +: INDEX_WIDTH];
        end else begin
            rd_index = stage.addr[OFFSET_WIDTH +: INDEX_WIDTH];
        end
    end

endmodule

/* source/cache_resolve.sv */
// cache_resolve: hit compare, read response, write merge, LRU touch, miss hand-off, install
module cache_resolve (
    input  logic             clk,
    input  logic             rstn,
    req_stage_if.resolve     stage,
    set_read_if.resolve      rd,
    line_write_if.resolve    wr,
    refill_if.resolve        refill,
    output logic             rsp_valid,
    output cache_pkg::word_t rsp_data
);
    import cache_pkg::*;

    // replace one word of a line
    function automatic line_t merge_word(line_t base, word_sel_t sel, word_t data);
        line_t merged;
        merged = base;
        merged[sel*WORD_WIDTH +: WORD_WIDTH] = data;
        return merged;
    endfunction

    tag_t                req_tag;
    index_t              req_index;
    word_sel_t           req_sel;
    logic [NUM_WAYS-1:0] hit_vec;
    way_t                hit_way;
    line_t               hit_line;
    way_t                victim_way;
    way_t                victim_q;
    logic                pending;
    logic                lookup_hit;
    logic                miss_start;
    logic                fill_done;

    assign req_tag   = stage.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign req_index = stage.addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign req_sel   = stage.addr[OFFSET_WIDTH-1 -: $bits(word_sel_t)];

    // ====================
    // tag compare
    // ====================
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = rd.valid[w] && (rd.tag[w] == req_tag);
            if (hit_vec[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit_line   = rd.line[hit_way];
    assign lookup_hit = stage.valid && !pending && (|hit_vec);
    assign miss_start = stage.valid && !pending && !(|hit_vec);
    assign fill_done  = pending && refill.done;

    // hold drops in the done cycle so the next request can enter
    assign stage.hold = miss_start || (pending && !refill.done);

    // victim fields go to the refill controller with start
    assign victim_way          = rd.lru;
    assign refill.start        = miss_start;
    assign refill.victim_dirty = rd.valid[victim_way] && rd.dirty[victim_way];
    assign refill.victim_addr  = {rd.tag[victim_way], req_index, {OFFSET_WIDTH{1'b0}}};
    assign refill.victim_line  = rd.line[victim_way];
    assign refill.fill_addr    = {req_tag, req_index, {OFFSET_WIDTH{1'b0}}};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pending  <= 1'b0;
            victim_q <= '0;
        end else if (miss_start) begin
            pending  <= 1'b1;
            victim_q <= victim_way;
        end else if (refill.done) begin
            pending  <= 1'b0;
        end
    end

    // ====================
    // array update
    // ====================
    always_comb begin
        wr.we    = 1'b0;
        wr.touch = lookup_hit || fill_done;
        wr.way   = fill_done ? victim_q : hit_way;
        wr.index = req_index;
        wr.tag   = req_tag;
        wr.dirty = 1'b1;
        wr.line  = merge_word(hit_line, req_sel, stage.wdata);
        if (lookup_hit && stage.write) begin
            wr.we = 1'b1;
        end
        if (fill_done) begin
            // reads install clean, writes merged and dirty
            wr.we    = 1'b1;
            wr.dirty = stage.write;
            if (stage.write) begin
                wr.line = merge_word(refill.fill_line, req_sel, stage.wdata);
            end else begin
                wr.line = refill.fill_line;
            end
        end
    end

    // read responses only
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= (lookup_hit || fill_done) && !stage.write;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_hit) begin
            rsp_data <= hit_line[req_sel*WORD_WIDTH +: WORD_WIDTH];
        end else if (fill_done) begin
            rsp_data <= refill.fill_line[req_sel*WORD_WIDTH +: WORD_WIDTH];
        end
    end

endmodule

/* source/cache_refill.sv */
// cache_refill: miss FSM for dirty victim write-back and line fetch
module cache_refill (
    input  logic             clk,
    input  logic             rstn,
    refill_if.refill         refill,
    output logic             mem_req_valid,
    output logic             mem_req_write,
    output cache_pkg::addr_t mem_req_addr,
    output cache_pkg::line_t mem_req_wdata,
    input  logic             mem_req_ready,
    input  logic             mem_rsp_valid,
    input  cache_pkg::line_t mem_rsp_line
);
    import cache_pkg::*;

    refill_state_t state;
    refill_state_t next_state;

    addr_t victim_addr_q;
    line_t victim_line_q;
    addr_t fill_addr_q;
    line_t fill_line_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ====================
    // next state
    // ====================
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (refill.start) begin
                    next_state = refill.victim_dirty ? WRITEBACK : FETCH_REQ;
                end
            end
            WRITEBACK:  if (mem_req_ready) next_state = FETCH_REQ;
            FETCH_REQ:  if (mem_req_ready) next_state = FETCH_WAIT;
            FETCH_WAIT: if (mem_rsp_valid) next_state = DONE;
            DONE:       next_state = IDLE;
            default:    next_state = IDLE;
        endcase
    end

    // miss fields captured at start, fetched line at response
    always_ff @(posedge clk) begin
        if (state == IDLE && refill.start) begin
            victim_addr_q <= refill.victim_addr;
            victim_line_q <= refill.victim_line;
            fill_addr_q   <= refill.fill_addr;
        end
        if (state == FETCH_WAIT && mem_rsp_valid) begin
            fill_line_q <= mem_rsp_line;
        end
    end

    // request fields stay steady while valid is up
    assign mem_req_valid  = (state == WRITEBACK) || (state == FETCH_REQ);
    assign mem_req_write  = (state == WRITEBACK);
    assign mem_req_addr   = (state == WRITEBACK) ? victim_addr_q : fill_addr_q;
    assign mem_req_wdata  = victim_line_q;
    assign refill.done      = (state == DONE);
    assign refill.fill_line = fill_line_q;

endmodule

/* source/cache_top.sv */
// cache_top: two-way write-back data cache, lookup and resolve stages with refill unit
module cache_top (
    input  logic             clk,
    input  logic             rstn,
    input  logic             req_valid,
    input  logic             req_write,
    input  cache_pkg::addr_t req_addr,
    input  cache_pkg::word_t req_wdata,
    output logic             req_ready,
    output logic             rsp_valid,
    output cache_pkg::word_t rsp_data,
    output logic             mem_req_valid,
    output logic             mem_req_write,
    output cache_pkg::addr_t mem_req_addr,
    output cache_pkg::line_t mem_req_wdata,
    input  logic             mem_req_ready,
    input  logic             mem_rsp_valid,
    input  cache_pkg::line_t mem_rsp_line
);
    import cache_pkg::*;

    index_t rd_index;

    req_stage_if  stage_bus ();
    set_read_if   set_bus ();
    line_write_if wr_bus ();
    refill_if     refill_bus ();

    // ====================
    // pipeline
    // ====================
    cache_lookup u_lookup (
        .clk       (clk),
        .rstn      (rstn),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_ready (req_ready),
        .rd_index  (rd_index),
        .stage     (stage_bus)
    );

    cache_arrays u_arrays (
        .clk      (clk),
        .rstn     (rstn),
        .rd_index (rd_index),
        .rd       (set_bus),
        .wr       (wr_bus)
    );

    cache_resolve u_resolve (
        .clk       (clk),
        .rstn      (rstn),
        .stage     (stage_bus),
        .rd        (set_bus),
        .wr        (wr_bus),
        .refill    (refill_bus),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

    // miss side unit on the memory port
    cache_refill u_refill (
        .clk           (clk),
        .rstn          (rstn),
        .refill        (refill_bus),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_req_addr  (mem_req_addr),
        .mem_req_wdata (mem_req_wdata),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_line  (mem_rsp_line)
    );

endmodule

/* test/mem_pattern.svh */
// pattern_word, the initial memory word for a word address
`ifndef MEM_PATTERN_SVH
`define MEM_PATTERN_SVH

// low half is the word address, high half its inverse
function automatic cache_pkg::word_t pattern_word(input logic [13:0] word_addr);
    logic [15:0] a;
    a = {2'b00, word_addr};
    return {~a, a};
endfunction

`endif

/* test/cache_properties.sv */
// shadow memory, expected read queue and port assertions of the cache, with the bind to its top
`include "mem_pattern.svh"

module cache_properties (
    input logic             clk,
    input logic             rstn,
    input logic             req_valid,
    input logic             req_write,
    input cache_pkg::addr_t req_addr,
    input cache_pkg::word_t req_wdata,
    input logic             req_ready,
    input logic             rsp_valid,
    input cache_pkg::word_t rsp_data,
    input logic             mem_req_valid,
    input logic             mem_req_write,
    input cache_pkg::addr_t mem_req_addr,
    input cache_pkg::line_t mem_req_wdata,
    input logic             mem_req_ready
);
    timeunit 1ns;
    timeprecision 1ps;
    import cache_pkg::*;

    int unsigned fail_count = 0;

    // word shadow holds the pattern until first written
    word_t          shadow [1 << (ADDR_WIDTH-2)];
    logic [16383:0] written;
    logic [4095:0]  line_dirty;

    // expected read words in acceptance order
    word_t      exp_mem [256];
    logic [7:0] exp_wr;
    logic [7:0] exp_rd;
    word_t      exp_head;
    line_t      shadow_line;
    logic [11:0] wb_line;
    logic       accept;

    // line of the most recently accepted request
    logic [11:0] last_line;
    logic        last_valid;
    logic        same_line;

    function automatic word_t shadow_word(logic [13:0] w);
        return written[w] ? shadow[w] : pattern_word(w);
    endfunction

    assign accept      = req_valid && req_ready;
    assign exp_head    = exp_mem[exp_rd];
    assign wb_line     = mem_req_addr[ADDR_WIDTH-1:OFFSET_WIDTH];
    assign shadow_line = {shadow_word({wb_line, 2'd3}), shadow_word({wb_line, 2'd2}),
                          shadow_word({wb_line, 2'd1}), shadow_word({wb_line, 2'd0})};
    assign same_line   = last_valid && (req_addr[ADDR_WIDTH-1:OFFSET_WIDTH] == last_line);

    always @(posedge clk) begin
        if (accept && req_write) begin
            shadow[req_addr[ADDR_WIDTH-1:2]] <= req_wdata;
        end
        if (accept && !req_write) begin
            exp_mem[exp_wr] <= shadow_word(req_addr[ADDR_WIDTH-1:2]);
        end
    end

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            exp_wr     <= '0;
            exp_rd     <= '0;
            written    <= '0;
            line_dirty <= '0;
            last_line  <= '0;
            last_valid <= 1'b0;
        end else begin
            if (accept) begin
                last_valid <= 1'b1;
                last_line  <= req_addr[ADDR_WIDTH-1:OFFSET_WIDTH];
            end
            if (accept && req_write) begin
                written[req_addr[ADDR_WIDTH-1:2]]               <= 1'b1;
                line_dirty[req_addr[ADDR_WIDTH-1:OFFSET_WIDTH]] <= 1'b1;
            end
            if (accept && !req_write) begin
                exp_wr <= exp_wr + 8'd1;
            end
            if (mem_req_valid && mem_req_ready && mem_req_write) begin
                line_dirty[wb_line] <= 1'b0;
            end
            if (rsp_valid) begin
                exp_rd <= exp_rd + 8'd1;
            end
        end
    end

    // ====================
    // assertions
    // ====================
    reset_idle: assert property (@(posedge clk)
        $rose(rstn) |-> req_ready && !rsp_valid && !mem_req_valid)
        else begin
            $error("Mismatch at %0t: req_ready,rsp_valid,mem_req_valid got %b%b%b expected 100",
                   $time, $sampled(req_ready), $sampled(rsp_valid), $sampled(mem_req_valid));
            fail_count++;
        end

    rsp_in_order: assert property (@(posedge clk) disable iff (!rstn)
        rsp_valid |-> (exp_wr != exp_rd) && (rsp_data == exp_head))
        else begin
            $error("Mismatch at %0t: rsp_data got %h expected %h",
                   $time, $sampled(rsp_data), $sampled(exp_head));
            fail_count++;
        end

    // the previous request left its line resident and a read of it must hit
    resident_hit: assert property (@(posedge clk) disable iff (!rstn)
        (accept && !req_write && same_line)
        |=> (req_ready && !mem_req_valid) ##1 (rsp_valid && !mem_req_valid))
        else begin
            $error("Read of a line just used was no two-cycle hit, seen at %0t", $time);
            fail_count++;
        end

    writeback_line: assert property (@(posedge clk) disable iff (!rstn)
        mem_req_valid && mem_req_write |-> mem_req_wdata == shadow_line)
        else begin
            $error("Mismatch at %0t: mem_req_wdata got %h expected %h",
                   $time, $sampled(mem_req_wdata), $sampled(shadow_line));
            fail_count++;
        end

    writeback_dirty: assert property (@(posedge clk) disable iff (!rstn)
        mem_req_valid && mem_req_write |-> line_dirty[wb_line])
        else begin
            $error("Memory write at %0t for line %h that holds no written data",
                   $time, $sampled(mem_req_addr));
            fail_count++;
        end

    req_stable: assert property (@(posedge clk) disable iff (!rstn)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_write)
        && $stable(mem_req_addr) && $stable(mem_req_wdata))
        else begin
            $error("Memory request at %0t changed before mem_req_ready", $time);
            fail_count++;
        end

    // a fetch asks for the base of the waiting request's line
    fill_line_addr: assert property (@(posedge clk) disable iff (!rstn)
        mem_req_valid && !mem_req_write |-> mem_req_addr == {last_line, {OFFSET_WIDTH{1'b0}}})
        else begin
            $error("Mismatch at %0t: mem_req_addr got %h expected %h",
                   $time, $sampled(mem_req_addr), {$sampled(last_line), 4'h0});
            fail_count++;
        end

endmodule

bind cache_top cache_properties props (.*);

/* test/tb_cache.sv */
// tb_cache: clock, reset, directed and random stimulus, line memory model, closing report
`include "mem_pattern.svh"

module tb_cache;
    timeunit 1ns;
    timeprecision 1ps;
    import cache_pkg::*;

    localparam int WAIT_LIMIT = 400;

    logic  clk;
    logic  rstn;
    logic  req_valid;
    logic  req_write;
    addr_t req_addr;
    word_t req_wdata;
    logic  req_ready;
    logic  rsp_valid;
    word_t rsp_data;
    logic  mem_req_valid;
    logic  mem_req_write;
    addr_t mem_req_addr;
    line_t mem_req_wdata;
    logic  mem_req_ready;
    logic  mem_rsp_valid;
    line_t mem_rsp_line;

    line_t mem [1 << (ADDR_WIDTH-OFFSET_WIDTH)];
    logic  fetch_busy;
    int    fetch_delay;
    line_t fetch_line;
    int    errors = 0;
    int    reads_sent = 0;
    int    rsp_seen = 0;

    cache_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #2ms;
        $display("Watchdog expired before the stimulus finished");
        $display("Test failures found");
        $finish;
    end

    always @(posedge clk) begin
        if (rsp_valid) begin
            rsp_seen++;
        end
    end

    // ====================
    // memory model
    // ====================
    initial begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_line  = '0;
        fetch_busy    = 1'b0;
        fetch_delay   = 0;
        for (int i = 0; i < (1 << (ADDR_WIDTH-2)); i++) begin
            mem[i / 4][(i % 4)*WORD_WIDTH +: WORD_WIDTH] = pattern_word(14'(i));
        end
        forever begin
            @(posedge clk);
            mem_rsp_valid <= 1'b0;
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req_write) begin
                    mem[mem_req_addr[ADDR_WIDTH-1:OFFSET_WIDTH]] = mem_req_wdata;
                end else begin
                    fetch_busy  = 1'b1;
                    fetch_delay = int'($urandom_range(3, 0));
                    fetch_line  = mem[mem_req_addr[ADDR_WIDTH-1:OFFSET_WIDTH]];
                end
            end else if (fetch_busy) begin
                if (fetch_delay == 0) begin
                    mem_rsp_valid <= 1'b1;
                    mem_rsp_line  <= fetch_line;
                    fetch_busy     = 1'b0;
                end else begin
                    fetch_delay--;
                end
            end
            mem_req_ready <= ($urandom_range(3, 0) != 0);
        end
    end

    // called on a rising edge, returns on the accepting edge
    task automatic send(input logic write, input addr_t addr, input word_t data);
        int waited;
        waited = 0;
        req_valid <= 1'b1;
        req_write <= write;
        req_addr  <= addr;
        req_wdata <= data;
        @(negedge clk);
        while (!req_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready) begin
            $display("Timeout at %0t waiting for req_ready, address %h", $time, addr);
            errors++;
        end else if (!write) begin
            reads_sent++;
        end
        @(posedge clk);
    endtask

    // wait for every read answered and no miss in progress
    task automatic drain();
        int waited;
        waited = 0;
        req_valid <= 1'b0;
        @(negedge clk);
        while (!(req_ready && !mem_req_valid && rsp_seen == reads_sent)
               && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= WAIT_LIMIT) begin
            $display("Timeout at %0t waiting for the cache to go idle", $time);
            errors++;
        end
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(32'hcd17_21a7));
        rstn      = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        // read miss, then the same word as a hit
        send(1'b0, 16'h0100, '0);
        drain();
        send(1'b0, 16'h0100, '0);
        drain();

        // write hit with a read right behind it
        send(1'b1, 16'h0104, 32'h5a5a_0104);
        send(1'b0, 16'h0104, '0);
        drain();

        // set 16, dirty line ends up least recently used
        send(1'b0, 16'h0300, '0);
        drain();
        send(1'b0, 16'h0500, '0);
        drain();
        send(1'b0, 16'h0100, '0);
        drain();

        // ====================
        // random mix
        // ====================
        repeat (300) begin
            send(1'($urandom_range(1, 0)), {5'b0, 9'($urandom_range(511, 0)), 2'b00},
                 $urandom);
            if ($urandom_range(3, 0) == 0) begin
                req_valid <= 1'b0;
                @(posedge clk);
            end
        end
        drain();

        if (rsp_seen != reads_sent) begin
            $display("Saw %0d read responses for %0d accepted reads", rsp_seen, reads_sent);
            errors++;
        end
        $display("Assertion failures %0d, other errors %0d, reads %0d, responses %0d",
                 dut.props.fail_count, errors, reads_sent, rsp_seen);
        if (dut.props.fail_count == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+test
source/cache_pkg.sv
source/cache_if.sv
source/cache_arrays.sv
source/cache_lookup.sv
source/cache_resolve.sv
source/cache_refill.sv
source/cache_top.sv
test/cache_properties.sv
test/tb_cache.sv

/* Makefile */
# Verilator flow for the two-way data cache

VERILATOR ?= verilator
TOP       ?= tb_cache
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
